/* hw/bus_pkg.sv */
package bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [3:0]  reg_idx_t;  // word index inside a window
    typedef logic [3:0]  page_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        DECERR = 2'b11
    } resp_e;

    typedef enum logic [1:0] {
        SAW      = 2'd0,
        SQUARE   = 2'd1,
        TRIANGLE = 2'd2
    } wave_e;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESP
    } port_state_e;

    typedef struct packed {
        addr_t addr;
    } aw_chan_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_chan_t;

    typedef struct packed {
        resp_e resp;
    } b_chan_t;

    typedef struct packed {
        addr_t addr;
    } ar_chan_t;

    typedef struct packed {
        data_t data;
        resp_e resp;
    } r_chan_t;

    // one byte per field, shown page by page on the LEDs
    typedef struct packed {
        logic [7:0] wr_count;
        logic [7:0] rd_count;
        logic [5:0] wr_pad;
        resp_e      wr_resp;
        logic [5:0] rd_pad;
        resp_e      rd_resp;
    } bus_status_t;

    localparam int SLAVE_COUNT = 2;

    // slave 0 register bank, slave 1 dds
    localparam logic [0:SLAVE_COUNT-1][31:0] WIN_START = {32'h0000_0000, 32'h4000_0000};
    localparam logic [0:SLAVE_COUNT-1][31:0] WIN_END   = {32'h0FFF_FFFF, 32'h4FFF_FFFF};

    localparam logic [3:15][7:0] LED_PATTERNS = {
        8'h0F, 8'hF0, 8'h0F, 8'hAA, 8'h55, 8'hF0, 8'h0F,
        8'h01, 8'h02, 8'h04, 8'h08, 8'h3C, 8'hC3
    };

endpackage

/* hw/axi_reg_port.sv */
`timescale 1ns/1ps

module axi_reg_port (
    input  logic                clk_50m,
    input  logic                arst_n,
    input  bus_pkg::aw_chan_t   aw,
    input  logic                aw_valid,
    output logic                aw_ready,
    input  bus_pkg::w_chan_t    w,
    input  logic                w_valid,
    output logic                w_ready,
    output bus_pkg::b_chan_t    b,
    output logic                b_valid,
    input  logic                b_ready,
    input  bus_pkg::ar_chan_t   ar,
    input  logic                ar_valid,
    output logic                ar_ready,
    output bus_pkg::r_chan_t    r,
    output logic                r_valid,
    input  logic                r_ready,
    output logic                wr_en,
    output bus_pkg::reg_idx_t   wr_idx,
    output bus_pkg::data_t      wr_data,
    output bus_pkg::strb_t      wr_strb,
    output bus_pkg::reg_idx_t   rd_idx,
    input  bus_pkg::data_t      rd_data
);

    bus_pkg::port_state_e state_q;
    logic                 is_wr_q;
    bus_pkg::data_t       r_data_q;

    always_ff @(posedge clk_50m or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= bus_pkg::IDLE;
            is_wr_q <= 1'b0;
        end else begin
            case (state_q)
                bus_pkg::IDLE: begin
                    if (aw_valid && w_valid) begin  // write wins over read
                        state_q <= bus_pkg::ACCESS;
                        is_wr_q <= 1'b1;
                    end else if (ar_valid) begin
                        state_q <= bus_pkg::ACCESS;
                        is_wr_q <= 1'b0;
                    end
                end
                bus_pkg::ACCESS: state_q <= bus_pkg::RESP;
                bus_pkg::RESP: begin
                    if (is_wr_q ? b_ready : r_ready) begin
                        state_q <= bus_pkg::IDLE;
                    end
                end
                default: state_q <= bus_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_50m) begin
        if (ar_ready) begin
            r_data_q <= rd_data;
        end
    end

    assign aw_ready = (state_q == bus_pkg::ACCESS) && is_wr_q;
    assign w_ready  = aw_ready;
    assign ar_ready = (state_q == bus_pkg::ACCESS) && !is_wr_q;

    assign wr_en   = aw_ready;  // one strobe per accepted write
    assign wr_idx  = aw.addr[5:2];
    assign wr_data = w.data;
    assign wr_strb = w.strb;
    assign rd_idx  = ar.addr[5:2];

    assign b       = '{resp: bus_pkg::OKAY};
    assign b_valid = (state_q == bus_pkg::RESP) && is_wr_q;
    assign r       = '{data: r_data_q, resp: bus_pkg::OKAY};
    assign r_valid = (state_q == bus_pkg::RESP) && !is_wr_q;

    // request must still be offered when it is accepted
    a_accept_needs_valid: assert property (@(posedge clk_50m) disable iff (!arst_n)
        state_q == bus_pkg::ACCESS |-> (is_wr_q ? aw_valid && w_valid : ar_valid));

endmodule

/* hw/reg_bank_slave.sv */
`timescale 1ns/1ps

module reg_bank_slave (
    input  logic                clk_50m,
    input  logic                arst_n,
    input  bus_pkg::aw_chan_t   aw,
    input  logic                aw_valid,
    output logic                aw_ready,
    input  bus_pkg::w_chan_t    w,
    input  logic                w_valid,
    output logic                w_ready,
    output bus_pkg::b_chan_t    b,
    output logic                b_valid,
    input  logic                b_ready,
    input  bus_pkg::ar_chan_t   ar,
    input  logic                ar_valid,
    output logic                ar_ready,
    output bus_pkg::r_chan_t    r,
    output logic                r_valid,
    input  logic                r_ready
);

    logic              wr_en;
    bus_pkg::reg_idx_t wr_idx;
    bus_pkg::data_t    wr_data;
    bus_pkg::strb_t    wr_strb;
    bus_pkg::reg_idx_t rd_idx;
    bus_pkg::data_t    rd_data;
    bus_pkg::data_t    regs_q [16];

    axi_reg_port axi_reg_port_inst (.*);

    always_ff @(posedge clk_50m or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            for (int n = 0; n < 4; n++) begin
                if (wr_strb[n]) begin
                    regs_q[wr_idx][8*n +: 8] <= wr_data[8*n +: 8];
                end
            end
        end
    end

    assign rd_data = regs_q[rd_idx];

endmodule

/* hw/dds_slave.sv */
`timescale 1ns/1ps

module dds_slave (
    input  logic                clk_50m,
    input  logic                arst_n,
    input  bus_pkg::aw_chan_t   aw,
    input  logic                aw_valid,
    output logic                aw_ready,
    input  bus_pkg::w_chan_t    w,
    input  logic                w_valid,
    output logic                w_ready,
    output bus_pkg::b_chan_t    b,
    output logic                b_valid,
    input  logic                b_ready,
    input  bus_pkg::ar_chan_t   ar,
    input  logic                ar_valid,
    output logic                ar_ready,
    output bus_pkg::r_chan_t    r,
    output logic                r_valid,
    input  logic                r_ready,
    output logic [7:0]          da_data
);

    logic              wr_en;
    bus_pkg::reg_idx_t wr_idx;
    bus_pkg::data_t    wr_data;
    bus_pkg::strb_t    wr_strb;
    bus_pkg::reg_idx_t rd_idx;
    bus_pkg::data_t    rd_data;
    bus_pkg::data_t    freq_q;
    bus_pkg::data_t    phase_q;
    bus_pkg::wave_e    wave_q;

    axi_reg_port axi_reg_port_inst (.*);

    always_ff @(posedge clk_50m or negedge arst_n) begin
        if (!arst_n) begin
            freq_q  <= '0;
            phase_q <= '0;
            wave_q  <= bus_pkg::SAW;
            da_data <= 8'h00;
        end else begin
            phase_q <= phase_q + freq_q;
            if (wr_en && wr_idx == 4'd0) begin
                for (int n = 0; n < 4; n++) begin
                    if (wr_strb[n]) begin
                        freq_q[8*n +: 8] <= wr_data[8*n +: 8];
                    end
                end
            end
            if (wr_en && wr_idx == 4'd1 && wr_strb[0]) begin
                wave_q <= bus_pkg::wave_e'(wr_data[1:0]);
            end
            case (wave_q)
                bus_pkg::SQUARE:   da_data <= {8{phase_q[31]}};
                bus_pkg::TRIANGLE: da_data <= phase_q[31] ? ~phase_q[30:23] : phase_q[30:23];
                default:           da_data <= phase_q[31:24];  // saw
            endcase
        end
    end

    always_comb begin
        case (rd_idx)
            4'd0:    rd_data = freq_q;
            4'd1:    rd_data = {30'b0, wave_q};
            4'd2:    rd_data = phase_q;
            default: rd_data = '0;
        endcase
    end

endmodule

/* hw/axi_decoder.sv */
`timescale 1ns/1ps

module axi_decoder (
    input  logic                                          clk_50m,
    input  logic                                          arst_n,
    input  bus_pkg::aw_chan_t                             m_aw,
    input  logic                                          m_aw_valid,
    output logic                                          m_aw_ready,
    input  bus_pkg::w_chan_t                              m_w,
    input  logic                                          m_w_valid,
    output logic                                          m_w_ready,
    output bus_pkg::b_chan_t                              m_b,
    output logic                                          m_b_valid,
    input  logic                                          m_b_ready,
    input  bus_pkg::ar_chan_t                             m_ar,
    input  logic                                          m_ar_valid,
    output logic                                          m_ar_ready,
    output bus_pkg::r_chan_t                              m_r,
    output logic                                          m_r_valid,
    input  logic                                          m_r_ready,
    output bus_pkg::aw_chan_t [bus_pkg::SLAVE_COUNT-1:0]  s_aw,
    output logic [bus_pkg::SLAVE_COUNT-1:0]               s_aw_valid,
    input  logic [bus_pkg::SLAVE_COUNT-1:0]               s_aw_ready,
    output bus_pkg::w_chan_t [bus_pkg::SLAVE_COUNT-1:0]   s_w,
    output logic [bus_pkg::SLAVE_COUNT-1:0]               s_w_valid,
    input  logic [bus_pkg::SLAVE_COUNT-1:0]               s_w_ready,
    input  bus_pkg::b_chan_t [bus_pkg::SLAVE_COUNT-1:0]   s_b,
    input  logic [bus_pkg::SLAVE_COUNT-1:0]               s_b_valid,
    output logic [bus_pkg::SLAVE_COUNT-1:0]               s_b_ready,
    output bus_pkg::ar_chan_t [bus_pkg::SLAVE_COUNT-1:0]  s_ar,
    output logic [bus_pkg::SLAVE_COUNT-1:0]               s_ar_valid,
    input  logic [bus_pkg::SLAVE_COUNT-1:0]               s_ar_ready,
    input  bus_pkg::r_chan_t [bus_pkg::SLAVE_COUNT-1:0]   s_r,
    input  logic [bus_pkg::SLAVE_COUNT-1:0]               s_r_valid,
    output logic [bus_pkg::SLAVE_COUNT-1:0]               s_r_ready,
    output bus_pkg::bus_status_t                          status
);

    logic [bus_pkg::SLAVE_COUNT-1:0] wr_hit;
    logic [bus_pkg::SLAVE_COUNT-1:0] rd_hit;
    logic [bus_pkg::SLAVE_COUNT-1:0] wr_sel_q;  // held until b transfers
    logic [bus_pkg::SLAVE_COUNT-1:0] rd_sel_q;
    logic [bus_pkg::SLAVE_COUNT-1:0] w_sel;
    logic                            aw_done;
    logic                            w_done;
    logic                            ar_done;
    logic                            w_known;

    always_comb begin
        for (int i = 0; i < bus_pkg::SLAVE_COUNT; i++) begin
            wr_hit[i] = (m_aw.addr >= bus_pkg::WIN_START[i]) &&
                        (m_aw.addr <= bus_pkg::WIN_END[i]);
            rd_hit[i] = (m_ar.addr >= bus_pkg::WIN_START[i]) &&
                        (m_ar.addr <= bus_pkg::WIN_END[i]);
        end
    end

    assign w_sel   = aw_done ? wr_sel_q : wr_hit;
    assign w_known = aw_done || m_aw_valid;  // w may not run ahead of its address

    always_comb begin
        for (int i = 0; i < bus_pkg::SLAVE_COUNT; i++) begin
            s_aw[i]       = m_aw;
            s_aw_valid[i] = m_aw_valid && !aw_done && wr_hit[i];
            s_w[i]        = m_w;
            s_w_valid[i]  = m_w_valid && !w_done && w_known && w_sel[i];
            s_b_ready[i]  = m_b_ready && aw_done && wr_sel_q[i];
            s_ar[i]       = m_ar;
            s_ar_valid[i] = m_ar_valid && !ar_done && rd_hit[i];
            s_r_ready[i]  = m_r_ready && ar_done && rd_sel_q[i];
        end
    end

    // unmapped requests are taken at once
    assign m_aw_ready = m_aw_valid && !aw_done && (~|wr_hit || |(wr_hit & s_aw_ready));
    assign m_w_ready  = m_w_valid && !w_done && w_known && (~|w_sel || |(w_sel & s_w_ready));
    assign m_ar_ready = m_ar_valid && !ar_done && (~|rd_hit || |(rd_hit & s_ar_ready));

    always_comb begin
        m_b       = '{resp: bus_pkg::DECERR};
        m_b_valid = aw_done && w_done && ~|wr_sel_q;
        m_r       = '{data: '0, resp: bus_pkg::DECERR};
        m_r_valid = ar_done && ~|rd_sel_q;
        for (int i = 0; i < bus_pkg::SLAVE_COUNT; i++) begin
            if (wr_sel_q[i]) begin
                m_b       = s_b[i];
                m_b_valid = aw_done && s_b_valid[i];
            end
            if (rd_sel_q[i]) begin
                m_r       = s_r[i];
                m_r_valid = ar_done && s_r_valid[i];
            end
        end
    end

    always_ff @(posedge clk_50m or negedge arst_n) begin
        if (!arst_n) begin
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
            ar_done  <= 1'b0;
            wr_sel_q <= '0;
            rd_sel_q <= '0;
            status   <= '0;
        end else begin
            if (m_b_valid && m_b_ready) begin
                aw_done         <= 1'b0;
                w_done          <= 1'b0;
                status.wr_count <= status.wr_count + 8'd1;  // wraps at 256
                status.wr_resp  <= m_b.resp;
            end else begin
                if (m_aw_valid && m_aw_ready) begin
                    aw_done  <= 1'b1;
                    wr_sel_q <= wr_hit;
                end
                if (m_w_valid && m_w_ready) begin
                    w_done <= 1'b1;
                end
            end
            if (m_r_valid && m_r_ready) begin
                ar_done         <= 1'b0;
                status.rd_count <= status.rd_count + 8'd1;
                status.rd_resp  <= m_r.resp;
            end else if (m_ar_valid && m_ar_ready) begin
                ar_done  <= 1'b1;
                rd_sel_q <= rd_hit;
            end
        end
    end

    a_aw_hold: assert property (@(posedge clk_50m) disable iff (!arst_n)
        m_aw_valid && !m_aw_ready |=> m_aw_valid);
    a_w_hold: assert property (@(posedge clk_50m) disable iff (!arst_n)
        m_w_valid && !m_w_ready |=> m_w_valid);
    a_ar_hold: assert property (@(posedge clk_50m) disable iff (!arst_n)
        m_ar_valid && !m_ar_ready |=> m_ar_valid);
    a_one_slave: assert property (@(posedge clk_50m) disable iff (!arst_n)
        $onehot0(s_aw_valid) && $onehot0(s_w_valid) && $onehot0(s_ar_valid));

endmodule

/* hw/led_page_display.sv */
`timescale 1ns/1ps

module led_page_display (
    input  logic                  clk_50m,
    input  logic                  arst_n,
    input  logic                  btn_up,
    input  logic                  btn_down,
    input  bus_pkg::bus_status_t  status,
    output logic [7:0]            led8,
    output bus_pkg::page_t        led4
);

    logic [2:0]     up_q;  // two sync flops plus edge history
    logic [2:0]     down_q;
    logic           up_rise;
    logic           down_rise;
    bus_pkg::page_t page_q;
    logic [7:0]     page_byte;

    assign up_rise   = up_q[1] && !up_q[2];
    assign down_rise = down_q[1] && !down_q[2];

    always_ff @(posedge clk_50m or negedge arst_n) begin
        if (!arst_n) begin
            up_q   <= 3'b000;
            down_q <= 3'b000;
            page_q <= '0;
        end else begin
            up_q   <= {up_q[1:0], btn_up};
            down_q <= {down_q[1:0], btn_down};
            if (up_rise && !down_rise) begin
                page_q <= page_q + 4'd1;  // wraps at 16
            end else if (down_rise && !up_rise) begin
                page_q <= page_q - 4'd1;
            end
        end
    end

    always_comb begin
        case (page_q)
            4'd0:    page_byte = status.wr_count;
            4'd1:    page_byte = status.rd_count;
            4'd2:    page_byte = {4'b0, status.wr_resp, status.rd_resp};
            default: page_byte = bus_pkg::LED_PATTERNS[page_q];
        endcase
    end

    assign led8 = ~page_byte;  // active low leds
    assign led4 = page_q;

endmodule

/* hw/board_ctrl_top.sv */
`timescale 1ns/1ps

module board_ctrl_top (
    input  logic                clk_50m,
    input  logic                arst_n,
    input  bus_pkg::aw_chan_t   m_aw,
    input  logic                m_aw_valid,
    output logic                m_aw_ready,
    input  bus_pkg::w_chan_t    m_w,
    input  logic                m_w_valid,
    output logic                m_w_ready,
    output bus_pkg::b_chan_t    m_b,
    output logic                m_b_valid,
    input  logic                m_b_ready,
    input  bus_pkg::ar_chan_t   m_ar,
    input  logic                m_ar_valid,
    output logic                m_ar_ready,
    output bus_pkg::r_chan_t    m_r,
    output logic                m_r_valid,
    input  logic                m_r_ready,
    input  logic [1:0]          btn,
    output logic [7:0]          led8,
    output bus_pkg::page_t      led4,
    output logic [7:0]          da_data
);

    bus_pkg::aw_chan_t [bus_pkg::SLAVE_COUNT-1:0] s_aw;
    logic [bus_pkg::SLAVE_COUNT-1:0]              s_aw_valid;
    logic [bus_pkg::SLAVE_COUNT-1:0]              s_aw_ready;
    bus_pkg::w_chan_t [bus_pkg::SLAVE_COUNT-1:0]  s_w;
    logic [bus_pkg::SLAVE_COUNT-1:0]              s_w_valid;
    logic [bus_pkg::SLAVE_COUNT-1:0]              s_w_ready;
    bus_pkg::b_chan_t [bus_pkg::SLAVE_COUNT-1:0]  s_b;
    logic [bus_pkg::SLAVE_COUNT-1:0]              s_b_valid;
    logic [bus_pkg::SLAVE_COUNT-1:0]              s_b_ready;
    bus_pkg::ar_chan_t [bus_pkg::SLAVE_COUNT-1:0] s_ar;
    logic [bus_pkg::SLAVE_COUNT-1:0]              s_ar_valid;
    logic [bus_pkg::SLAVE_COUNT-1:0]              s_ar_ready;
    bus_pkg::r_chan_t [bus_pkg::SLAVE_COUNT-1:0]  s_r;
    logic [bus_pkg::SLAVE_COUNT-1:0]              s_r_valid;
    logic [bus_pkg::SLAVE_COUNT-1:0]              s_r_ready;
    bus_pkg::bus_status_t                         status;

    axi_decoder axi_decoder_inst (.*);

    // window 0
    reg_bank_slave reg_bank_slave_inst (
        .clk_50m  (clk_50m      ),
        .arst_n   (arst_n       ),
        .aw       (s_aw      [0]),
        .aw_valid (s_aw_valid[0]),
        .aw_ready (s_aw_ready[0]),
        .w        (s_w       [0]),
        .w_valid  (s_w_valid [0]),
        .w_ready  (s_w_ready [0]),
        .b        (s_b       [0]),
        .b_valid  (s_b_valid [0]),
        .b_ready  (s_b_ready [0]),
        .ar       (s_ar      [0]),
        .ar_valid (s_ar_valid[0]),
        .ar_ready (s_ar_ready[0]),
        .r        (s_r       [0]),
        .r_valid  (s_r_valid [0]),
        .r_ready  (s_r_ready [0])
    );

    // window 1
    dds_slave dds_slave_inst (
        .clk_50m  (clk_50m      ),
        .arst_n   (arst_n       ),
        .aw       (s_aw      [1]),
        .aw_valid (s_aw_valid[1]),
        .aw_ready (s_aw_ready[1]),
        .w        (s_w       [1]),
        .w_valid  (s_w_valid [1]),
        .w_ready  (s_w_ready [1]),
        .b        (s_b       [1]),
        .b_valid  (s_b_valid [1]),
        .b_ready  (s_b_ready [1]),
        .ar       (s_ar      [1]),
        .ar_valid (s_ar_valid[1]),
        .ar_ready (s_ar_ready[1]),
        .r        (s_r       [1]),
        .r_valid  (s_r_valid [1]),
        .r_ready  (s_r_ready [1]),
        .da_data  (da_data      )
    );

    led_page_display led_page_display_inst (
        .clk_50m  (clk_50m),
        .arst_n   (arst_n ),
        .btn_up   (btn[0] ),
        .btn_down (btn[1] ),
        .status   (status ),
        .led8     (led8   ),
        .led4     (led4   )
    );

endmodule

/* verif/tb_board_ctrl.sv */
`timescale 1ns/1ps

module tb_board_ctrl;

    localparam int            TIMEOUT  = 200;   // cycles per wait
    localparam int            GOLD_MAX = 160;   // five words per golden line
    localparam bus_pkg::addr_t DDS_FREQ = 32'h4000_0000;
    localparam bus_pkg::addr_t DDS_WAVE = 32'h4000_0004;

    logic                 clk_50m;
    logic                 arst_n;
    bus_pkg::aw_chan_t    m_aw;
    logic                 m_aw_valid;
    logic                 m_aw_ready;
    bus_pkg::w_chan_t     m_w;
    logic                 m_w_valid;
    logic                 m_w_ready;
    bus_pkg::b_chan_t     m_b;
    logic                 m_b_valid;
    logic                 m_b_ready;
    bus_pkg::ar_chan_t    m_ar;
    logic                 m_ar_valid;
    logic                 m_ar_ready;
    bus_pkg::r_chan_t     m_r;
    logic                 m_r_valid;
    logic                 m_r_ready;
    logic [1:0]           btn;
    logic [7:0]           led8;
    bus_pkg::page_t       led4;
    logic [7:0]           da_data;

    logic [31:0]          golden_q [0:GOLD_MAX-1];
    logic [15:0]          lfsr_q = 16'd6720;
    logic [7:0]           wr_cnt = 8'd0;  // own count of b transfers
    logic [7:0]           rd_cnt = 8'd0;
    bus_pkg::resp_e       last_wr_resp = bus_pkg::OKAY;
    bus_pkg::resp_e       last_rd_resp = bus_pkg::OKAY;
    int                   errors = 0;
    int                   tests_run = 0;
    int                   tests_bad = 0;
    bit                   hung = 1'b0;

    board_ctrl_top board_ctrl_top_inst (.*);

    initial begin
        clk_50m = 1'b0;
        forever #4 clk_50m = ~clk_50m;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // two lfsr bits give 0 to 3 cycles
    function automatic int ready_delay();
        int d;
        d = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            d = d * 2 + int'(lfsr_q[0]);
        end
        return d;
    endfunction

    // even samples climb and odd ones fall, phase bit 23 stays clear
    function automatic logic [7:0] tri_next(input logic [7:0] prev);
        if (!prev[0]) begin
            return (prev == 8'hFE) ? 8'hFF : prev + 8'd2;
        end
        return (prev == 8'h01) ? 8'h00 : prev - 8'd2;
    endfunction

    function automatic logic [7:0] page_byte(input bus_pkg::page_t p);
        case (p)
            4'd0:    return wr_cnt;
            4'd1:    return rd_cnt;
            4'd2:    return {4'b0, last_wr_resp, last_rd_resp};
            default: return bus_pkg::LED_PATTERNS[p];
        endcase
    endfunction

    task automatic check_resp(input string name, input bus_pkg::resp_e got,
                              input bus_pkg::resp_e exp);
        if (got !== exp) begin
            $display("Error: %0t ns %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_data(input string name, input bus_pkg::data_t got,
                              input bus_pkg::data_t exp);
        if (got !== exp) begin
            $display("Error: %0t ns %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("Error: %0t ns %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout at %0t ns, %s after %0d cycles", $time, what, TIMEOUT);
        errors++;
        hung = 1'b1;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %-24s ok", name);
        end else begin
            tests_bad++;
            $display("test %-24s mismatch", name);
        end
    endtask

    // leaves ready high at the negedge before the transfer edge
    task automatic await_response(input bit is_write, input int delay);
        int cycles;
        cycles = 0;
        @(negedge clk_50m);
        while (!(is_write ? m_b_valid : m_r_valid) && cycles < TIMEOUT) begin
            @(negedge clk_50m);
            cycles++;
        end
        if (!(is_write ? m_b_valid : m_r_valid)) begin
            note_timeout(is_write ? "no write response" : "no read response");
            return;
        end
        repeat (delay) @(posedge clk_50m);
        @(posedge clk_50m);
        #1;
        m_b_ready = is_write;
        m_r_ready = !is_write;
        @(negedge clk_50m);
        if (!(is_write ? m_b_valid : m_r_valid)) begin
            $display("response valid dropped before its ready at %0t ns", $time);
            errors++;
        end
    endtask

    task automatic bus_write(input bus_pkg::addr_t addr, input bus_pkg::data_t data,
                             input bus_pkg::strb_t strb, input bus_pkg::resp_e exp_resp);
        logic aw_hs;
        logic w_hs;
        int   cycles;
        int   delay;
        delay      = ready_delay();
        m_aw       = '{addr: addr};
        m_w        = '{data: data, strb: strb};
        m_aw_valid = 1'b1;
        m_w_valid  = 1'b1;
        cycles     = 0;
        while ((m_aw_valid || m_w_valid) && cycles < TIMEOUT) begin
            @(negedge clk_50m);
            aw_hs = m_aw_valid && m_aw_ready;
            w_hs  = m_w_valid && m_w_ready;
            @(posedge clk_50m);
            #1;
            m_aw_valid = m_aw_valid && !aw_hs;
            m_w_valid  = m_w_valid && !w_hs;
            cycles++;
        end
        if (m_aw_valid || m_w_valid) begin
            note_timeout("write request not accepted");
            return;
        end
        await_response(1'b1, delay);
        if (hung) begin
            return;
        end
        check_resp("m_b.resp", m_b.resp, exp_resp);
        @(posedge clk_50m);
        #1;
        m_b_ready    = 1'b0;
        wr_cnt       = wr_cnt + 8'd1;
        last_wr_resp = exp_resp;
    endtask

    task automatic bus_read(input bus_pkg::addr_t addr, input bus_pkg::data_t exp_data,
                            input bus_pkg::resp_e exp_resp);
        logic hs;
        int   cycles;
        int   delay;
        delay      = ready_delay();
        m_ar       = '{addr: addr};
        m_ar_valid = 1'b1;
        cycles     = 0;
        while (m_ar_valid && cycles < TIMEOUT) begin
            @(negedge clk_50m);
            hs = m_ar_ready;
            @(posedge clk_50m);
            #1;
            m_ar_valid = !hs;
            cycles++;
        end
        if (m_ar_valid) begin
            note_timeout("read request not accepted");
            return;
        end
        await_response(1'b0, delay);
        if (hung) begin
            return;
        end
        check_data("m_r.data", m_r.data, exp_data);
        check_resp("m_r.resp", m_r.resp, exp_resp);
        @(posedge clk_50m);
        #1;
        m_r_ready    = 1'b0;
        rd_cnt       = rd_cnt + 8'd1;
        last_rd_resp = exp_resp;
    endtask

    task automatic check_reset();
        @(negedge clk_50m);
        check_byte("ready and valid bits",
                   {3'b0, m_aw_ready, m_w_ready, m_ar_ready, m_b_valid, m_r_valid}, 8'h00);
        check_byte("da_data", da_data, 8'h00);
        check_byte("led4", {4'b0, led4}, 8'h00);
        check_byte("led8", led8, 8'hFF);
        @(posedge clk_50m);
        #1;
    endtask

    task automatic check_wave(input bus_pkg::wave_e wave);
        logic [7:0] prev;
        logic [7:0] cur;
        logic [7:0] exp;
        bit         seen_low;
        bit         seen_high;
        int         errs0;
        bus_write(DDS_WAVE, {30'b0, wave}, 4'hF, bus_pkg::OKAY);
        bus_read(DDS_WAVE, {30'b0, wave}, bus_pkg::OKAY);
        if (hung) begin
            return;
        end
        seen_low  = 1'b0;
        seen_high = 1'b0;
        errs0     = errors;
        @(negedge clk_50m);
        prev = da_data;
        for (int i = 0; i < 300; i++) begin  // longer than one triangle period
            @(negedge clk_50m);
            cur = da_data;
            case (wave)
                bus_pkg::SAW:    exp = prev + 8'd1;
                bus_pkg::SQUARE: exp = (cur == 8'hFF) ? 8'hFF : 8'h00;
                default:         exp = tri_next(prev);
            endcase
            check_byte("da_data", cur, exp);
            seen_low  = seen_low || (cur == 8'h00);
            seen_high = seen_high || (cur == 8'hFF);
            prev      = cur;
            if (errors != errs0) begin
                break;
            end
        end
        if (wave == bus_pkg::SQUARE && !(seen_low && seen_high)) begin
            $display("square output never changed level by %0t ns", $time);
            errors++;
        end
        @(posedge clk_50m);
        #1;
    endtask

    task automatic run_golden();
        logic [31:0] op;
        for (int i = 0; i < GOLD_MAX; i += 5) begin
            op = golden_q[i];
            if (op == 32'd0 || hung) begin
                break;
            end
            if (op == 32'd1) begin
                bus_write(golden_q[i+1], golden_q[i+2], golden_q[i+3][3:0],
                          bus_pkg::resp_e'(golden_q[i+4][1:0]));
            end else begin
                bus_read(golden_q[i+1], golden_q[i+2], bus_pkg::resp_e'(golden_q[i+4][1:0]));
            end
        end
    endtask

    task automatic press_button(input int which, input bus_pkg::page_t exp_page);
        int cycles;
        btn[which] = 1'b1;
        cycles     = 0;
        @(negedge clk_50m);
        while (led4 != exp_page && cycles < TIMEOUT) begin
            @(negedge clk_50m);
            cycles++;
        end
        if (led4 != exp_page) begin
            note_timeout("led4 did not reach the next page");
        end
        check_byte("led4", {4'b0, led4}, {4'b0, exp_page});
        check_byte("led8", led8, ~page_byte(exp_page));  // leds are active low
        @(posedge clk_50m);
        #1;
        btn[which] = 1'b0;
        repeat (4) @(posedge clk_50m);  // release must pass the sync flops
        #1;
    endtask

    initial begin
        int errs0;
        arst_n     = 1'b0;
        m_aw       = '0;
        m_aw_valid = 1'b0;
        m_w        = '0;
        m_w_valid  = 1'b0;
        m_b_ready  = 1'b0;
        m_ar       = '0;
        m_ar_valid = 1'b0;
        m_r_ready  = 1'b0;
        btn        = 2'b00;
        $readmemh("verif/bus_golden.txt", golden_q);
        repeat (16) @(posedge clk_50m);
        #1;
        arst_n = 1'b1;

        errs0 = errors;
        check_reset();
        finish_test("reset state", errs0);

        if (!hung) begin
            errs0 = errors;
            bus_write(DDS_FREQ, 32'h0100_0000, 4'hF, bus_pkg::OKAY);
            bus_read(DDS_FREQ, 32'h0100_0000, bus_pkg::OKAY);
            check_wave(bus_pkg::SAW);
            check_wave(bus_pkg::SQUARE);
            check_wave(bus_pkg::TRIANGLE);
            finish_test("dds registers and waves", errs0);
        end
        if (!hung) begin
            errs0 = errors;
            run_golden();
            finish_test("golden bus operations", errs0);
        end
        if (!hung) begin
            errs0 = errors;
            press_button(0, 4'd1);  // read count
            press_button(1, 4'd0);  // write count
            press_button(0, 4'd1);
            press_button(0, 4'd2);  // last responses
            finish_test("led status pages", errs0);
        end
        if (!hung) begin
            errs0 = errors;
            for (int p = 3; p < 16 && !hung; p++) begin
                press_button(0, 4'(p));
            end
            if (!hung) begin
                press_button(0, 4'd0);  // wraps
            end
            finish_test("led pattern pages", errs0);
        end

        $display("tests %0d, failing %0d, errors %0d", tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verif/bus_golden.txt */
// fields op addr data strb resp with op 1 write, op 2 read and op 0 end
// read lines carry the expected data, resp 0 is okay and 3 is decerr
1 00000000 11223344 F 0
2 00000000 11223344 0 0
1 00000000 AABBCCDD 1 0
2 00000000 112233DD 0 0
1 00000000 EEFF0000 C 0
2 00000000 EEFF33DD 0 0
1 00000004 CAFEF00D 6 0
2 00000004 00FEF000 0 0
2 00000008 00000000 0 0
1 20000000 12345678 F 3
2 20000000 00000000 0 3
1 0000003C 12345678 F 0
1 00000040 DEADBEEF 3 0
2 00000000 EEFFBEEF 0 0
2 10000000 00000000 0 3
2 40000000 01000000 0 0
1 40000004 00000000 1 0
2 40000004 00000000 0 0
2 4000000C 00000000 0 0
1 0FFFFFFC 0000A5A5 3 0
1 FFFFFFFC 00000001 F 3
2 0000003C 1234A5A5 0 0
0 00000000 00000000 0 0

/* files.f */
hw/bus_pkg.sv
hw/axi_reg_port.sv
hw/reg_bank_slave.sv
hw/dds_slave.sv
hw/axi_decoder.sv
hw/led_page_display.sv
hw/board_ctrl_top.sv
verif/tb_board_ctrl.sv

/* Makefile */
SRCS := $(shell grep -v '^+' files.f)

.PHONY: run clean

run: obj_dir/Vtb_board_ctrl
	obj_dir/Vtb_board_ctrl | tee sim.log
	grep -qx "Test passed" sim.log

obj_dir/Vtb_board_ctrl: files.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_board_ctrl -f files.f

clean:
	rm -rf obj_dir sim.log
